// ==== vlog.f ====
+incdir+hdl
hdl/npc_pkg.sv
hdl/npc_ifu.sv
hdl/npc_gpr.sv
hdl/npc_idu.sv
hdl/npc_exu.sv
hdl/npc_lsu.sv
hdl/npc_core.sv
bench/npc_tb.sv

// ==== Bender.yml ====
package:
  name: npc

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/npc_pkg.sv
      - hdl/npc_ifu.sv
      - hdl/npc_gpr.sv
      - hdl/npc_idu.sv
      - hdl/npc_exu.sv
      - hdl/npc_lsu.sv
      - hdl/npc_core.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/npc_tb.sv

// ==== bench/npc_tb.sv ====
// Testbench for npc_core with clock, instruction ROM, APB memory model, directed tests and watchdog.
`timescale 1ns/1ps
`include "npc_config.svh"

module npc_tb import npc_pkg::*; ();

  localparam int          CLK_PERIOD  = 8;
  localparam int          ROM_WORDS   = 64;
  localparam int          MAX_WAIT    = 3;   // two lfsr bits per transfer.
  localparam int          NUM_TESTS   = 6;
  localparam int          TOTAL_INSTS = 64;  // all programs together, rounded up.
  localparam int          WATCHDOG_CYCLES = TOTAL_INSTS * (2 + MAX_WAIT) + NUM_TESTS * 24;
  localparam logic [63:0] BASE        = `NPC_RESET_PC;
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
  localparam logic [31:0] FENCE_WORD  = 32'h0000_000f;

  logic        clk;
  logic        rst;
  logic [63:0] imem_addr;
  logic [31:0] imem_data;
  logic [63:0] rom_off;
  apb_req_t    apb;
  logic [63:0] prdata;
  logic        pready;
  logic        halt;
  logic        illegal;

  logic [31:0] rom [ROM_WORDS];
  int          plen;
  logic [63:0] dmem [logic [63:0]];
  logic [63:0] log_addr [$];
  logic [63:0] log_data [$];
  logic [63:0] exp_addr [$];
  logic [63:0] exp_data [$];
  logic [31:0] lfsr;
  int          errors;
  int          failed_tests;

  apb_req_t    held_req;
  logic [63:0] held_pc;
  logic        fresh;
  logic        ready;
  int          waits_left;

  npc_core DUT (
    .i_clk       (clk),
    .i_rst       (rst),
    .o_imem_addr (imem_addr),
    .i_imem_data (imem_data),
    .o_apb       (apb),
    .i_prdata    (prdata),
    .i_pready    (pready),
    .o_halt      (halt),
    .o_illegal   (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  assign rom_off = imem_addr - BASE;

  always_comb begin
    if (rom_off < ROM_WORDS * 4) begin
      imem_data = rom[rom_off >> 2];
    end else begin
      imem_data = 32'h0;  // decodes as illegal.
    end
  end

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [63:0] fill_word(input logic [63:0] addr);
    return ~addr ^ {addr[31:0], addr[63:32]};
  endfunction

  function automatic logic [63:0] read_mem(input logic [63:0] addr);
    return dmem.exists(addr) ? dmem[addr] : fill_word(addr);
  endfunction

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [63:0] lui_addi_value(input logic [19:0] h, input logic [11:0] l);
    return {{32{h[19]}}, h, 12'b0} + sext12(l);
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] h);
    return {h, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] ld_word(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] off);
    return {off, rs1, 3'b011, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] sd_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b011, off[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // apb slave sampled and driven 1 ns after each rising edge.
  always begin
    @(posedge clk);
    #1;
    ready = 1'b0;
    if (apb.psel && !apb.penable) begin
      held_req = apb;
      held_pc  = imem_addr;
      fresh    = 1'b1;
    end else if (apb.psel) begin
      if (fresh) begin
        waits_left = int'(take_bits(2));
        fresh      = 1'b0;
      end
      expect_eq("pwrite", apb.pwrite, held_req.pwrite);
      expect_eq("paddr", apb.paddr, held_req.paddr);
      expect_eq("pwdata", apb.pwdata, held_req.pwdata);
      expect_eq("imem_addr", imem_addr, held_pc);
      if (waits_left > 0) begin
        waits_left--;
      end else begin
        ready = 1'b1;
        if (apb.pwrite) begin
          dmem[apb.paddr] = apb.pwdata;
          log_addr.push_back(apb.paddr);
          log_data.push_back(apb.pwdata);
        end else begin
          prdata = read_mem(apb.paddr);
        end
      end
    end
    pready = ready;
  end

  task automatic emit(input logic [31:0] w);
    rom[plen] = w;
    plen++;
  endtask

  task automatic store_and_expect(input logic [4:0] rs2, input logic [11:0] off,
                                  input logic [63:0] value);
    emit(sd_word(rs2, 5'd0, off));
    exp_addr.push_back(sext12(off));
    exp_data.push_back(value);
  endtask

  // reset is held while the next program is loaded.
  task automatic begin_test();
    @(posedge clk);
    #1;
    rst = 1'b1;
    foreach (rom[i]) begin
      rom[i] = 32'h0;
    end
    plen = 0;
    dmem.delete();
    log_addr.delete();
    log_data.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic release_reset();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  task automatic run_to_halt(input string name);
    int n;
    n = 0;
    while (!halt && n < plen * (2 + MAX_WAIT) + 8) begin
      @(posedge clk);
      #1;
      n++;
    end
    assert (halt) else begin
      $display("test %s: core did not halt within %0d cycles", name, n);
      errors++;
    end
  endtask

  task automatic check_log();
    expect_eq("store count", log_addr.size(), exp_addr.size());
    if (log_addr.size() == exp_addr.size()) begin
      foreach (exp_addr[i]) begin
        expect_eq($sformatf("store %0d paddr", i), log_addr[i], exp_addr[i]);
        expect_eq($sformatf("store %0d pwdata", i), log_data[i], exp_data[i]);
      end
    end
  endtask

  task automatic report_test(input string name, input int errs0);
    if (errors == errs0) begin
      $display("test %-8s ok", name);
    end else begin
      $display("test %-8s failed with %0d errors", name, errors - errs0);
      failed_tests++;
    end
  endtask

  task automatic test_reset();
    int errs0;
    errs0 = errors;
    begin_test();
    emit(addi_word(5'd1, 5'd0, 12'd1));
    emit(EBREAK_WORD);
    release_reset();
    expect_eq("imem_addr", imem_addr, BASE);
    expect_eq("psel", apb.psel, 1'b0);
    expect_eq("halt", halt, 1'b0);
    expect_eq("illegal", illegal, 1'b0);
    run_to_halt("reset");
    report_test("reset", errs0);
  endtask

  task automatic test_arith();
    logic [19:0] h1;
    logic [19:0] h2;
    logic [11:0] l1;
    logic [11:0] l2;
    logic [11:0] ir;
    logic [63:0] a;
    logic [63:0] b;
    int          errs0;
    errs0 = errors;
    begin_test();
    h1 = 20'(take_bits(20));
    l1 = 12'(take_bits(12));
    h2 = 20'(take_bits(20));
    l2 = 12'(take_bits(12));
    ir = 12'(take_bits(12));
    a  = lui_addi_value(h1, l1);
    b  = lui_addi_value(h2, l2);
    emit(lui_word(5'd1, h1));
    emit(addi_word(5'd1, 5'd1, l1));
    emit(lui_word(5'd2, h2));
    emit(addi_word(5'd2, 5'd2, l2));
    emit(rtype_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    store_and_expect(5'd3, 12'd0, a + b);
    emit(rtype_word(7'h20, 3'b000, 5'd3, 5'd1, 5'd2));
    store_and_expect(5'd3, 12'd8, a - b);
    emit(rtype_word(7'h00, 3'b111, 5'd3, 5'd1, 5'd2));
    store_and_expect(5'd3, 12'd16, a & b);
    emit(rtype_word(7'h00, 3'b110, 5'd3, 5'd1, 5'd2));
    store_and_expect(5'd3, 12'd24, a | b);
    emit(rtype_word(7'h00, 3'b100, 5'd3, 5'd1, 5'd2));
    store_and_expect(5'd3, 12'd32, a ^ b);
    emit(rtype_word(7'h00, 3'b010, 5'd3, 5'd1, 5'd2));
    store_and_expect(5'd3, 12'd40, {63'b0, $signed(a) < $signed(b)});
    emit(rtype_word(7'h00, 3'b010, 5'd3, 5'd2, 5'd1));
    store_and_expect(5'd3, 12'd48, {63'b0, $signed(b) < $signed(a)});
    emit(addi_word(5'd3, 5'd1, ir));
    store_and_expect(5'd3, 12'd56, a + sext12(ir));
    store_and_expect(5'd1, 12'd64, a);
    emit(EBREAK_WORD);
    release_reset();
    run_to_halt("arith");
    check_log();
    report_test("arith", errs0);
  endtask

  task automatic test_load();
    logic [63:0] addr;
    int          errs0;
    errs0 = errors;
    begin_test();
    for (int k = 0; k < 4; k++) begin
      addr       = 64'd256 + 8 * k;
      dmem[addr] = take_bits(64);
      emit(ld_word(5'd5, 5'd0, addr[11:0]));
      emit(addi_word(5'd5, 5'd5, 12'(k + 1)));
      store_and_expect(5'd5, 12'(512 + 8 * k), dmem[addr] + k + 1);
    end
    emit(EBREAK_WORD);
    release_reset();
    run_to_halt("load");
    check_log();
    report_test("load", errs0);
  endtask

  task automatic test_branch();
    logic [63:0] link;
    int          errs0;
    errs0 = errors;
    begin_test();
    emit(addi_word(5'd1, 5'd0, 12'd5));
    emit(addi_word(5'd2, 5'd0, 12'd5));
    emit(addi_word(5'd3, 5'd0, 12'd7));
    emit(branch_word(3'b000, 5'd1, 5'd2, 13'd8));  // beq taken.
    emit(sd_word(5'd1, 5'd0, 12'h300));
    emit(branch_word(3'b001, 5'd1, 5'd2, 13'd8));  // bne not taken.
    store_and_expect(5'd3, 12'h100, 64'd7);
    emit(branch_word(3'b001, 5'd1, 5'd3, 13'd8));  // bne taken.
    emit(sd_word(5'd1, 5'd0, 12'h308));
    emit(branch_word(3'b000, 5'd1, 5'd3, 13'd8));  // beq not taken.
    store_and_expect(5'd2, 12'h108, 64'd5);
    link = BASE + 4 * plen + 4;
    emit(jal_word(5'd4, 21'd8));
    emit(sd_word(5'd1, 5'd0, 12'h310));
    store_and_expect(5'd4, 12'h110, link);
    emit(EBREAK_WORD);
    release_reset();
    run_to_halt("branch");
    check_log();
    report_test("branch", errs0);
  endtask

  task automatic test_ebreak();
    logic [63:0] stop_pc;
    int          errs0;
    errs0 = errors;
    begin_test();
    emit(addi_word(5'd1, 5'd0, 12'd9));
    store_and_expect(5'd1, 12'h40, 64'd9);
    stop_pc = BASE + 4 * plen;
    emit(EBREAK_WORD);
    emit(sd_word(5'd1, 5'd0, 12'h48));
    release_reset();
    run_to_halt("ebreak");
    expect_eq("illegal", illegal, 1'b0);
    expect_eq("imem_addr", imem_addr, stop_pc);
    repeat (8) begin
      @(posedge clk);
      #1;
      expect_eq("psel", apb.psel, 1'b0);
      expect_eq("imem_addr", imem_addr, stop_pc);
    end
    check_log();
    report_test("ebreak", errs0);
  endtask

  task automatic test_illegal();
    logic [63:0] stop_pc;
    int          errs0;
    errs0 = errors;
    begin_test();
    emit(addi_word(5'd1, 5'd0, 12'd3));
    store_and_expect(5'd1, 12'h80, 64'd3);
    stop_pc = BASE + 4 * plen;
    emit(FENCE_WORD);
    emit(sd_word(5'd1, 5'd0, 12'h88));
    emit(EBREAK_WORD);
    release_reset();
    run_to_halt("illegal");
    repeat (4) @(posedge clk);
    #1;
    expect_eq("illegal", illegal, 1'b1);
    expect_eq("halt", halt, 1'b1);
    expect_eq("imem_addr", imem_addr, stop_pc);
    check_log();
    report_test("illegal", errs0);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    rst          = 1'b1;
    pready       = 1'b0;
    prdata       = '0;
    lfsr         = 32'h1453_d3f1;
    errors       = 0;
    failed_tests = 0;
    plen         = 0;
    fresh        = 1'b0;
    waits_left   = 0;
    foreach (rom[i]) begin
      rom[i] = 32'h0;
    end
    test_reset();
    test_arith();
    test_load();
    test_branch();
    test_ebreak();
    test_illegal();
    $display("%0d of %0d tests failed, %0d errors", failed_tests, NUM_TESTS, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/npc_core.sv ====
// Core top level with fetch, decode, execute and load/store, plus sticky halt flags.
`timescale 1ns/1ps
`include "npc_config.svh"

module npc_core import npc_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst,
  output logic [`NPC_XLEN-1:0] o_imem_addr,
  input  logic [31:0]          i_imem_data,
  output apb_req_t             o_apb,
  input  logic [`NPC_XLEN-1:0] i_prdata,
  input  logic                 i_pready,
  output logic                 o_halt,
  output logic                 o_illegal
);

  logic [`NPC_XLEN-1:0] pc;
  logic [`NPC_XLEN-1:0] imm;
  logic [`NPC_XLEN-1:0] rs1data;
  logic [`NPC_XLEN-1:0] rs2data;
  logic [`NPC_XLEN-1:0] result;
  logic [`NPC_XLEN-1:0] target;
  logic [`NPC_XLEN-1:0] wb_data;
  ctrl_t                ctrl;
  ctrl_t                ctrl_lsu;
  logic                 taken;
  logic                 stall;
  logic                 wb_wen;
  logic                 halt_q;
  logic                 illegal_q;

  assign o_imem_addr = pc;

  npc_ifu u_ifu (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_stall  (stall),
    .i_halt   (halt_q | ctrl.halt),  // pc stays on the halting instruction.
    .i_taken  (taken),
    .i_target (target),
    .o_pc     (pc)
  );

  npc_idu u_idu (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_inst    (i_imem_data),
    .i_wb_wen  (wb_wen),
    .i_wb_data (wb_data),
    .o_ctrl    (ctrl),
    .o_imm     (imm),
    .o_rs1data (rs1data),
    .o_rs2data (rs2data)
  );

  npc_exu u_exu (
    .i_ctrl    (ctrl),
    .i_pc      (pc),
    .i_imm     (imm),
    .i_rs1data (rs1data),
    .i_rs2data (rs2data),
    .o_result  (result),
    .o_taken   (taken),
    .o_target  (target)
  );

  // no bus traffic or writeback once halted.
  always_comb begin
    ctrl_lsu = ctrl;
    if (halt_q) begin
      ctrl_lsu.mem_rd = 1'b0;
      ctrl_lsu.mem_wr = 1'b0;
      ctrl_lsu.rf_wen = 1'b0;
    end
  end

  npc_lsu u_lsu (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_ctrl    (ctrl_lsu),
    .i_addr    (result),   // rs1 + imm.
    .i_wdata   (rs2data),
    .i_result  (result),
    .i_prdata  (i_prdata),
    .i_pready  (i_pready),
    .o_apb     (o_apb),
    .o_stall   (stall),
    .o_wb_wen  (wb_wen),
    .o_wb_data (wb_data)
  );

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      halt_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      halt_q    <= halt_q | ctrl.halt;
      illegal_q <= illegal_q | ctrl.illegal;
    end
  end

  assign o_halt    = halt_q;
  assign o_illegal = illegal_q;

endmodule

// ==== hdl/npc_lsu.sv ====
// APB master FSM for LD/SD and the register writeback mux.
`timescale 1ns/1ps
`include "npc_config.svh"

module npc_lsu import npc_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  ctrl_t                i_ctrl,
  input  logic [`NPC_XLEN-1:0] i_addr,
  input  logic [`NPC_XLEN-1:0] i_wdata,
  input  logic [`NPC_XLEN-1:0] i_result,
  input  logic [`NPC_XLEN-1:0] i_prdata,
  input  logic                 i_pready,
  output apb_req_t             o_apb,
  output logic                 o_stall,
  output logic                 o_wb_wen,
  output logic [`NPC_XLEN-1:0] o_wb_data
);

  lsu_state_e state_q;
  lsu_state_e state_next;
  lsu_state_e phase;
  logic       mem_req;
  logic       done;

  assign mem_req = i_ctrl.mem_rd | i_ctrl.mem_wr;

  // setup overlaps the decode cycle of the memory instruction.
  always_comb begin
    if (state_q == LSU_ACCESS) begin
      phase = LSU_ACCESS;
    end else if (mem_req) begin
      phase = LSU_SETUP;
    end else begin
      phase = LSU_IDLE;
    end
  end

  assign done = (phase == LSU_ACCESS) && i_pready;

  always_comb begin
    case (phase)
      LSU_SETUP:  state_next = LSU_ACCESS;
      LSU_ACCESS: state_next = i_pready ? LSU_IDLE : LSU_ACCESS;
      default:    state_next = LSU_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= LSU_IDLE;
    end else begin
      state_q <= state_next;
    end
  end

  always_comb begin
    o_apb.psel    = (phase != LSU_IDLE);
    o_apb.penable = (phase == LSU_ACCESS);
    o_apb.pwrite  = i_ctrl.mem_wr;
    o_apb.paddr   = i_addr;   // held by the stalled pc.
    o_apb.pwdata  = i_wdata;
  end

  assign o_stall   = (phase != LSU_IDLE) && !done;
  assign o_wb_data = i_ctrl.mem_rd ? i_prdata : i_result;
  assign o_wb_wen  = i_ctrl.rf_wen && !o_stall;

  // the core must keep its decode inputs frozen until pready.
  a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_apb.psel && !done) |=>
      (o_apb.psel && o_apb.penable &&
       $stable(o_apb.pwrite) && $stable(o_apb.paddr) && $stable(o_apb.pwdata)));

endmodule

// ==== hdl/npc_exu.sv ====
// ALU with link and LUI results, and the branch/jump target unit.
`timescale 1ns/1ps
`include "npc_config.svh"

module npc_exu import npc_pkg::*; (
  input  ctrl_t                i_ctrl,
  input  logic [`NPC_XLEN-1:0] i_pc,
  input  logic [`NPC_XLEN-1:0] i_imm,
  input  logic [`NPC_XLEN-1:0] i_rs1data,
  input  logic [`NPC_XLEN-1:0] i_rs2data,
  output logic [`NPC_XLEN-1:0] o_result,
  output logic                 o_taken,
  output logic [`NPC_XLEN-1:0] o_target
);

  localparam logic [`NPC_XLEN-1:0] PC_STEP = 4;

  logic [`NPC_XLEN-1:0] op_b;
  logic [`NPC_XLEN-1:0] alu_out;
  logic                 lt;

  assign op_b = i_ctrl.b_is_imm ? i_imm : i_rs2data;
  assign lt   = $signed(i_rs1data) < $signed(op_b);

  always_comb begin
    case (i_ctrl.alu_op)
      ALU_ADD:    alu_out = i_rs1data + op_b;
      ALU_SUB:    alu_out = i_rs1data - op_b;
      ALU_AND:    alu_out = i_rs1data & op_b;
      ALU_OR:     alu_out = i_rs1data | op_b;
      ALU_XOR:    alu_out = i_rs1data ^ op_b;
      ALU_SLT:    alu_out = {{(`NPC_XLEN-1){1'b0}}, lt};
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = i_rs1data + op_b;
    endcase
  end

  // jal writes the return address.
  assign o_result = i_ctrl.link ? i_pc + PC_STEP : alu_out;

  always_comb begin
    case (i_ctrl.br_op)
      BR_BEQ:  o_taken = (i_rs1data == i_rs2data);
      BR_BNE:  o_taken = (i_rs1data != i_rs2data);
      BR_JAL:  o_taken = 1'b1;
      default: o_taken = 1'b0;
    endcase
  end

  assign o_target = i_pc + i_imm;  // pc-relative for branch and jal.

endmodule

// ==== hdl/npc_idu.sv ====
// Instruction decoder producing control and immediate, with the register file.
`timescale 1ns/1ps
`include "npc_config.svh"

module npc_idu import npc_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic [31:0]          i_inst,
  input  logic                 i_wb_wen,
  input  logic [`NPC_XLEN-1:0] i_wb_data,
  output ctrl_t                o_ctrl,
  output logic [`NPC_XLEN-1:0] o_imm,
  output logic [`NPC_XLEN-1:0] o_rs1data,
  output logic [`NPC_XLEN-1:0] o_rs2data
);

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } rv_opcode_e;

  localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [`NPC_XLEN-1:0] imm_i;
  logic [`NPC_XLEN-1:0] imm_s;
  logic [`NPC_XLEN-1:0] imm_b;
  logic [`NPC_XLEN-1:0] imm_u;
  logic [`NPC_XLEN-1:0] imm_j;
  logic                 bad;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{(`NPC_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`NPC_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`NPC_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                  i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(`NPC_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`NPC_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                  i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_ctrl        = '0;
    o_ctrl.alu_op = ALU_ADD;
    o_ctrl.br_op  = BR_SEQ;
    o_imm         = '0;
    bad           = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        o_ctrl.b_is_imm = 1'b1;
        o_ctrl.rf_wen   = 1'b1;
        o_imm           = imm_i;
        bad             = (funct3 != 3'b000);  // addi only.
      end
      OPC_OP: begin
        o_ctrl.rf_wen = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: o_ctrl.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: o_ctrl.alu_op = ALU_SUB;
          {7'b0000000, 3'b111}: o_ctrl.alu_op = ALU_AND;
          {7'b0000000, 3'b110}: o_ctrl.alu_op = ALU_OR;
          {7'b0000000, 3'b100}: o_ctrl.alu_op = ALU_XOR;
          {7'b0000000, 3'b010}: o_ctrl.alu_op = ALU_SLT;
          default:              bad = 1'b1;
        endcase
      end
      OPC_LUI: begin
        o_ctrl.alu_op   = ALU_PASS_B;
        o_ctrl.b_is_imm = 1'b1;
        o_ctrl.rf_wen   = 1'b1;
        o_imm           = imm_u;
      end
      OPC_LOAD: begin
        o_ctrl.b_is_imm = 1'b1;
        o_ctrl.rf_wen   = 1'b1;
        o_ctrl.mem_rd   = 1'b1;
        o_imm           = imm_i;
        bad             = (funct3 != 3'b011);  // ld only.
      end
      OPC_STORE: begin
        o_ctrl.b_is_imm = 1'b1;
        o_ctrl.mem_wr   = 1'b1;
        o_imm           = imm_s;
        bad             = (funct3 != 3'b011);  // sd only.
      end
      OPC_BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          3'b000:  o_ctrl.br_op = BR_BEQ;
          3'b001:  o_ctrl.br_op = BR_BNE;
          default: bad = 1'b1;
        endcase
      end
      OPC_JAL: begin
        o_ctrl.br_op  = BR_JAL;
        o_ctrl.link   = 1'b1;
        o_ctrl.rf_wen = 1'b1;
        o_imm         = imm_j;
      end
      OPC_SYSTEM: begin
        o_ctrl.halt = 1'b1;
        bad         = (i_inst != INST_EBREAK);
      end
      default: bad = 1'b1;
    endcase

    if (bad) begin  // nothing else of the instruction takes effect.
      o_ctrl         = '0;
      o_ctrl.alu_op  = ALU_ADD;
      o_ctrl.br_op   = BR_SEQ;
      o_ctrl.halt    = 1'b1;
      o_ctrl.illegal = 1'b1;
    end
  end

  npc_gpr u_gpr (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_raddr1 (i_inst[19:15]),
    .i_raddr2 (i_inst[24:20]),
    .i_waddr  (i_inst[11:7]),
    .i_wen    (i_wb_wen),
    .i_wdata  (i_wb_data),
    .o_rdata1 (o_rs1data),
    .o_rdata2 (o_rs2data)
  );

endmodule

// ==== hdl/npc_gpr.sv ====
// General purpose register file with two async read ports and one sync write port.
`timescale 1ns/1ps
`include "npc_config.svh"

module npc_gpr (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic [4:0]           i_raddr1,
  input  logic [4:0]           i_raddr2,
  input  logic [4:0]           i_waddr,
  input  logic                 i_wen,
  input  logic [`NPC_XLEN-1:0] i_wdata,
  output logic [`NPC_XLEN-1:0] o_rdata1,
  output logic [`NPC_XLEN-1:0] o_rdata2
);

  logic [`NPC_XLEN-1:0] regs [`NPC_NREGS];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `NPC_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != 5'd0) begin  // x0 writes dropped.
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == 5'd0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == 5'd0) ? '0 : regs[i_raddr2];

  // a write shows on the read port next cycle, x0 still reads zero.
  a_write_read: assert property (@(posedge i_clk) disable iff (i_rst)
    i_wen |=> (i_raddr1 != $past(i_waddr) ||
               o_rdata1 == (($past(i_waddr) == 5'd0) ? '0 : $past(i_wdata))));

endmodule

// ==== hdl/npc_ifu.sv ====
// Program counter register with next-PC selection and stall/halt hold.
`timescale 1ns/1ps
`include "npc_config.svh"

module npc_ifu (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_stall,
  input  logic                 i_halt,
  input  logic                 i_taken,
  input  logic [`NPC_XLEN-1:0] i_target,
  output logic [`NPC_XLEN-1:0] o_pc
);

  localparam logic [`NPC_XLEN-1:0] PC_STEP = 4;

  logic [`NPC_XLEN-1:0] pc_q;
  logic [`NPC_XLEN-1:0] pc_next;

  always_comb begin
    pc_next = i_taken ? i_target : pc_q + PC_STEP;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q <= `NPC_RESET_PC;
    end else if (!i_stall && !i_halt) begin  // hold while memory busy.
      pc_q <= pc_next;
    end
  end

  assign o_pc = pc_q;

  // branch and jump targets come from the decoder immediates.
  a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    o_pc[1:0] == 2'b00);

endmodule

// ==== hdl/npc_pkg.sv ====
// Package with ALU, next-PC and APB state enums and the control and APB request structs.
`include "npc_config.svh"

package npc_pkg;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6  // lui.
  } alu_op_e;

  typedef enum logic [1:0] {
    BR_SEQ = 2'd0,
    BR_BEQ = 2'd1,
    BR_BNE = 2'd2,
    BR_JAL = 2'd3
  } br_op_e;

  typedef enum logic [1:0] {
    LSU_IDLE   = 2'd0,
    LSU_SETUP  = 2'd1,
    LSU_ACCESS = 2'd2
  } lsu_state_e;

  typedef struct packed {
    alu_op_e alu_op;
    br_op_e  br_op;
    logic    b_is_imm;  // operand b from immediate.
    logic    rf_wen;
    logic    mem_rd;
    logic    mem_wr;
    logic    link;      // rd gets pc+4.
    logic    halt;
    logic    illegal;
  } ctrl_t;

  typedef struct packed {
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [`NPC_XLEN-1:0] paddr;
    logic [`NPC_XLEN-1:0] pwdata;
  } apb_req_t;

endpackage

// ==== hdl/npc_config.svh ====
// Core-wide data width, reset PC and register count macros.
`ifndef NPC_CONFIG_SVH
`define NPC_CONFIG_SVH

// data and address width.
`define NPC_XLEN 64

// first fetch address after reset.
`define NPC_RESET_PC 64'h8000_0000

// general purpose registers, x0 included.
`define NPC_NREGS 32

`endif
